//--- Bender.yml
package:
  name: threats

sources:
  - files:
      - rtl/gomoku_pkg.sv
      - rtl/threat_ifs.sv
      - rtl/threat_ctrl.sv
      - rtl/line_classifier.sv
      - rtl/cell_evaluator.sv
      - rtl/threat_collector.sv
      - rtl/threats.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_threats.sv

//--- compile.f
+incdir+include
rtl/gomoku_pkg.sv
rtl/threat_ifs.sv
rtl/threat_ctrl.sv
rtl/line_classifier.sv
rtl/cell_evaluator.sv
rtl/threat_collector.sv
rtl/threats.sv
tests/tb_threats.sv

//--- rtl/cell_evaluator.sv
// four direction windows, four classifiers and the registered cell grade
`timescale 1ns/1ps

module cell_evaluator (
    input  logic i_clk,
    input  logic i_rst_n,
    scan_if.dst  scan,
    eval_if.src  eval
);

    gomoku_pkg::line_t         win   [4];
    gomoku_pkg::threat_level_t level [4];
    gomoku_pkg::threat_level_t best;
    gomoku_pkg::cell_t         centre;
    logic                      valid_r;
    logic                      last_r;
    gomoku_pkg::coord_t        row_r;
    gomoku_pkg::coord_t        col_r;
    gomoku_pkg::threat_level_t level_r;

    function automatic gomoku_pkg::cell_t cell_at(
        input gomoku_pkg::board_t b,
        input int                 r,
        input int                 c
    );
        if (r < 0 || r >= gomoku_pkg::BOARD_N || c < 0 || c >= gomoku_pkg::BOARD_N)
            return gomoku_pkg::CELL_BLOCKED;
        return b[r * gomoku_pkg::BOARD_N + c];
    endfunction

    assign centre = cell_at(scan.board, int'(scan.row), int'(scan.col));

    // 0 horizontal, 1 vertical, 2 diagonal, 3 anti-diagonal
    always_comb begin
        for (int k = 0; k < 9; k++) begin
            win[0][k] = cell_at(scan.board, int'(scan.row), int'(scan.col) + k - 4);
            win[1][k] = cell_at(scan.board, int'(scan.row) + k - 4, int'(scan.col));
            win[2][k] = cell_at(scan.board, int'(scan.row) + k - 4, int'(scan.col) + k - 4);
            win[3][k] = cell_at(scan.board, int'(scan.row) + k - 4, int'(scan.col) - k + 4);
        end
    end

    for (genvar d = 0; d < 4; d++) begin : g_dir
        line_classifier u_line (
            .i_line   (win[d]),
            .i_colour (scan.colour),
            .o_level  (level[d])
        );
    end

    always_comb begin
        best = gomoku_pkg::NONE;
        for (int d = 0; d < 4; d++) begin
            if (level[d] > best)
                best = level[d];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_r <= 1'b0;
            last_r  <= 1'b0;
        end else begin
            valid_r <= scan.valid;
            last_r  <= scan.valid && scan.last;
        end
    end

    // occupied cells are not candidates
    always_ff @(posedge i_clk) begin
        row_r   <= scan.row;
        col_r   <= scan.col;
        level_r <= (centre == gomoku_pkg::EMPTY) ? best : gomoku_pkg::NONE;
    end

    assign eval.valid = valid_r;
    assign eval.last  = last_r;
    assign eval.row   = row_r;
    assign eval.col   = col_r;
    assign eval.level = level_r;

    // board stays captured for the whole scan, so the registered cell can be looked up again
    a_occupied_is_none: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        eval.valid
            && cell_at(scan.board, int'(eval.row), int'(eval.col)) != gomoku_pkg::EMPTY
            |-> eval.level == gomoku_pkg::NONE
    );

endmodule

//--- rtl/gomoku_pkg.sv
// board constants, cell/board/coordinate/line types and threat levels
package gomoku_pkg;

    // edge length of the square board
    localparam int BOARD_N = 15;
    localparam int NUM_CELLS = BOARD_N * BOARD_N;

    // stones in a row needed to win
    localparam int WIN_LEN = 5;

    // start edge to finish pulse, two passes plus pipeline
    localparam int SCAN_LATENCY = 2 * NUM_CELLS + 2;

    typedef enum logic [1:0] {
        BLACK = 2'd0,
        WHITE = 2'd1,
        EMPTY = 2'd2
    } cell_t;

    // off-board filler, neither colour nor empty
    localparam cell_t CELL_BLOCKED = cell_t'(2'b11);

    // cell index is row * BOARD_N + col, cell 0 in the lowest bits
    typedef cell_t [NUM_CELLS-1:0] board_t;

    typedef logic [3:0] coord_t;

    // larger value means stronger threat
    typedef enum logic [1:0] {
        NONE       = 2'd0,
        OPEN_THREE = 2'd1,
        FOUR       = 2'd2,
        FIVE       = 2'd3
    } threat_level_t;

    // nine cells along one direction, index 4 is the candidate
    typedef cell_t [8:0] line_t;

endpackage

//--- rtl/line_classifier.sv
// line_classifier: grades one nine-cell window around a candidate cell
`timescale 1ns/1ps

module line_classifier (
    input  gomoku_pkg::line_t         i_line,
    input  gomoku_pkg::cell_t         i_colour,
    output gomoku_pkg::threat_level_t o_level
);

    logic [2:0] run_hi;
    logic [2:0] run_lo;
    logic       stop_hi;
    logic       stop_lo;
    logic       open_hi;
    logic       open_lo;
    logic [3:0] run;

    // centre counts as a stone of i_colour, walk outwards on both sides
    always_comb begin
        run_hi  = 3'd0;
        run_lo  = 3'd0;
        stop_hi = 1'b0;
        stop_lo = 1'b0;
        open_hi = 1'b0;
        open_lo = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            if (!stop_hi) begin
                if (i_line[4+k] == i_colour) begin
                    run_hi = run_hi + 3'd1;
                end else begin
                    stop_hi = 1'b1;
                    open_hi = (i_line[4+k] == gomoku_pkg::EMPTY);
                end
            end
            if (!stop_lo) begin
                if (i_line[4-k] == i_colour) begin
                    run_lo = run_lo + 3'd1;
                end else begin
                    stop_lo = 1'b1;
                    open_lo = (i_line[4-k] == gomoku_pkg::EMPTY);
                end
            end
        end
    end

    assign run = 4'd1 + 4'(run_hi) + 4'(run_lo);

    always_comb begin
        if (run >= gomoku_pkg::WIN_LEN)
            o_level = gomoku_pkg::FIVE;
        else if (run == gomoku_pkg::WIN_LEN - 1 && (open_hi || open_lo))
            o_level = gomoku_pkg::FOUR;
        else if (run == gomoku_pkg::WIN_LEN - 2 && open_hi && open_lo)
            o_level = gomoku_pkg::OPEN_THREE;
        else
            o_level = gomoku_pkg::NONE;
    end

endmodule

//--- rtl/threat_collector.sv
// threat_collector: per-pass best level and position list, final attack/defend choice
`timescale 1ns/1ps

module threat_collector #(
    parameter int MAX_POS = 10
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    eval_if.dst                                 eval,
    output gomoku_pkg::coord_t [MAX_POS-1:0]    o_pos_x,
    output gomoku_pkg::coord_t [MAX_POS-1:0]    o_pos_y,
    output logic [5:0]                          o_size,
    output gomoku_pkg::threat_level_t           o_level,
    output logic                                o_defend,
    output logic                                o_finish
);

    // x is the row and y the column of a cell
    gomoku_pkg::threat_level_t          cur_level_r, nxt_level, att_level_r;
    gomoku_pkg::coord_t [MAX_POS-1:0]   cur_x_r, nxt_x, att_x_r;
    gomoku_pkg::coord_t [MAX_POS-1:0]   cur_y_r, nxt_y, att_y_r;
    logic [5:0]                         cur_cnt_r, nxt_cnt, att_cnt_r;
    logic                               pass_r;
    logic                               pend_r;

    // fold the arriving item into the running pass result
    always_comb begin
        nxt_level = cur_level_r;
        nxt_x     = cur_x_r;
        nxt_y     = cur_y_r;
        nxt_cnt   = cur_cnt_r;
        if (eval.valid && eval.level != gomoku_pkg::NONE) begin
            if (eval.level > cur_level_r) begin
                nxt_level = eval.level;
                nxt_x     = '0;
                nxt_y     = '0;
                nxt_x[0]  = eval.row;
                nxt_y[0]  = eval.col;
                nxt_cnt   = 6'd1;
            end else if (eval.level == cur_level_r) begin
                for (int i = 0; i < MAX_POS; i++) begin
                    if (cur_cnt_r == 6'(i)) begin
                        nxt_x[i] = eval.row;
                        nxt_y[i] = eval.col;
                    end
                end
                // count saturates
                if (cur_cnt_r != 6'd63)
                    nxt_cnt = cur_cnt_r + 6'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cur_level_r <= gomoku_pkg::NONE;
            cur_x_r     <= '0;
            cur_y_r     <= '0;
            cur_cnt_r   <= '0;
            att_level_r <= gomoku_pkg::NONE;
            att_x_r     <= '0;
            att_y_r     <= '0;
            att_cnt_r   <= '0;
            pass_r      <= 1'b0;
            pend_r      <= 1'b0;
            o_pos_x     <= '0;
            o_pos_y     <= '0;
            o_size      <= '0;
            o_level     <= gomoku_pkg::NONE;
            o_defend    <= 1'b0;
            o_finish    <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            if (pend_r) begin
                // ties go to the attacker
                if (att_level_r >= cur_level_r) begin
                    o_pos_x  <= att_x_r;
                    o_pos_y  <= att_y_r;
                    o_size   <= att_cnt_r;
                    o_level  <= att_level_r;
                    o_defend <= 1'b0;
                end else begin
                    o_pos_x  <= cur_x_r;
                    o_pos_y  <= cur_y_r;
                    o_size   <= cur_cnt_r;
                    o_level  <= cur_level_r;
                    o_defend <= (cur_level_r != gomoku_pkg::NONE);
                end
                o_finish    <= 1'b1;
                pend_r      <= 1'b0;
                cur_level_r <= gomoku_pkg::NONE;
                cur_x_r     <= '0;
                cur_y_r     <= '0;
                cur_cnt_r   <= '0;
            end else if (eval.valid && eval.last && !pass_r) begin
                // attack pass done, park it and start the defend pass clean
                att_level_r <= nxt_level;
                att_x_r     <= nxt_x;
                att_y_r     <= nxt_y;
                att_cnt_r   <= nxt_cnt;
                cur_level_r <= gomoku_pkg::NONE;
                cur_x_r     <= '0;
                cur_y_r     <= '0;
                cur_cnt_r   <= '0;
                pass_r      <= 1'b1;
            end else if (eval.valid) begin
                cur_level_r <= nxt_level;
                cur_x_r     <= nxt_x;
                cur_y_r     <= nxt_y;
                cur_cnt_r   <= nxt_cnt;
                if (eval.last) begin
                    pass_r <= 1'b0;
                    pend_r <= 1'b1;
                end
            end
        end
    end

    a_finish_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_finish |=> !o_finish
    );

    // reported size stays within the board and is zero exactly when nothing was found
    a_size_consistent: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_finish |-> o_size <= gomoku_pkg::NUM_CELLS
                     && ((o_level == gomoku_pkg::NONE) == (o_size == 6'd0))
    );

endmodule

//--- rtl/threat_ctrl.sv
// threat_ctrl: start control, board capture and two-pass cell scan counter
`timescale 1ns/1ps

module threat_ctrl (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  logic               i_turn,
    input  gomoku_pkg::board_t i_board,
    scan_if.src                scan
);

    logic               busy_r;
    logic               scan_r;
    logic               pass_r;
    logic               drain_r;
    logic               turn_r;
    gomoku_pkg::coord_t row_r;
    gomoku_pkg::coord_t col_r;
    gomoku_pkg::board_t board_r;
    logic               last_col;
    logic               last_cell;

    assign last_col  = (col_r == gomoku_pkg::coord_t'(gomoku_pkg::BOARD_N - 1));
    assign last_cell = last_col && (row_r == gomoku_pkg::coord_t'(gomoku_pkg::BOARD_N - 1));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_r  <= 1'b0;
            scan_r  <= 1'b0;
            pass_r  <= 1'b0;
            drain_r <= 1'b0;
            turn_r  <= 1'b0;
            row_r   <= '0;
            col_r   <= '0;
        end else if (!busy_r) begin
            if (i_start) begin
                busy_r  <= 1'b1;
                scan_r  <= 1'b1;
                pass_r  <= 1'b0;
                drain_r <= 1'b0;
                turn_r  <= i_turn;
                row_r   <= '0;
                col_r   <= '0;
            end
        end else if (scan_r) begin
            // row-major walk
            if (last_col) begin
                col_r <= '0;
                row_r <= last_cell ? '0 : row_r + 4'd1;
            end else begin
                col_r <= col_r + 4'd1;
            end
            if (last_cell) begin
                pass_r <= 1'b1;
                if (pass_r)
                    scan_r <= 1'b0;
            end
        end else begin
            // two drain cycles, idle again on the finish edge
            drain_r <= 1'b1;
            if (drain_r)
                busy_r <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy_r && i_start)
            board_r <= i_board;
    end

    assign scan.board  = board_r;
    assign scan.valid  = scan_r;
    assign scan.row    = row_r;
    assign scan.col    = col_r;
    // attack pass tests the side to move, defend pass the opponent
    assign scan.colour = gomoku_pkg::cell_t'({1'b0, turn_r ^ pass_r});
    assign scan.last   = scan_r && last_cell;

    a_no_scan_when_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !busy_r |-> !scan.valid
    );

endmodule

//--- rtl/threat_ifs.sv
// scan_if and eval_if internal interfaces
`timescale 1ns/1ps

// controller to evaluator, one cell per cycle
interface scan_if;
    gomoku_pkg::board_t board;
    logic               valid;
    gomoku_pkg::coord_t row;
    gomoku_pkg::coord_t col;
    gomoku_pkg::cell_t  colour;
    logic               last;

    modport src (output board, valid, row, col, colour, last);
    modport dst (input  board, valid, row, col, colour, last);
endinterface

// evaluator to collector, registered grade per cell
interface eval_if;
    logic                      valid;
    gomoku_pkg::coord_t        row;
    gomoku_pkg::coord_t        col;
    gomoku_pkg::threat_level_t level;
    logic                      last;

    modport src (output valid, row, col, level, last);
    modport dst (input  valid, row, col, level, last);
endinterface

//--- rtl/threats.sv
// threats: top level of the threat scanner, instances and wiring
`timescale 1ns/1ps

module threats #(
    parameter int MAX_POS = 10
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  logic                      i_turn,
    input  gomoku_pkg::board_t        i_board,
    output logic [MAX_POS*4-1:0]      o_pos_x,
    output logic [MAX_POS*4-1:0]      o_pos_y,
    output logic [5:0]                o_size,
    output gomoku_pkg::threat_level_t o_level,
    output logic                      o_defend,
    output logic                      o_finish
);

    scan_if scan_bus ();
    eval_if eval_bus ();

    threat_ctrl u_ctrl (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_turn  (i_turn),
        .i_board (i_board),
        .scan    (scan_bus.src)
    );

    cell_evaluator u_eval (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .scan    (scan_bus.dst),
        .eval    (eval_bus.src)
    );

    // slot 0 of each list in the lowest nibble
    threat_collector #(
        .MAX_POS (MAX_POS)
    ) u_collect (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .eval     (eval_bus.dst),
        .o_pos_x  (o_pos_x),
        .o_pos_y  (o_pos_y),
        .o_size   (o_size),
        .o_level  (o_level),
        .o_defend (o_defend),
        .o_finish (o_finish)
    );

endmodule

//--- include/tb_threats_tasks.svh
// reference model, compare tasks, stimulus helpers and directed tests for the threat scanner
`ifndef TB_THREATS_TASKS_SVH
`define TB_THREATS_TASKS_SVH

// per pass model result with index 0 attack and 1 defend
gomoku_pkg::threat_level_t pass_level [2];
int                        pass_cnt   [2];
gomoku_pkg::coord_t        pass_x     [2][MAX_POS];
gomoku_pkg::coord_t        pass_y     [2][MAX_POS];

gomoku_pkg::threat_level_t exp_level;
logic [5:0]                exp_size;
logic                      exp_defend;
gomoku_pkg::coord_t        exp_x [MAX_POS];
gomoku_pkg::coord_t        exp_y [MAX_POS];

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic compare_level(input gomoku_pkg::threat_level_t got,
                             input gomoku_pkg::threat_level_t exp, input string what);
    if (got !== exp)
        fail_run($sformatf("ERR @%0t: %s is %s, expected %s",
                           $time, what, got.name(), exp.name()));
endtask

task automatic compare_coord(input gomoku_pkg::coord_t got, input gomoku_pkg::coord_t exp,
                             input string what);
    if (got !== exp)
        fail_run($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic compare_size(input logic [5:0] got, input logic [5:0] exp, input string what);
    if (got !== exp)
        fail_run($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
        fail_run($sformatf("ERR @%0t: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic compare_cycles(input int got, input int exp, input string what);
    if (got != exp)
        fail_run($sformatf("ERR @%0t: %s is %0d cycles, expected %0d", $time, what, got, exp));
endtask

// off-board reads as code 3 which is neither a colour nor empty
function automatic gomoku_pkg::cell_t cell_on_board(input gomoku_pkg::board_t b,
                                                    input int r, input int c);
    if (r < 0 || c < 0 || r >= gomoku_pkg::BOARD_N || c >= gomoku_pkg::BOARD_N)
        return gomoku_pkg::cell_t'(2'b11);
    return b[r * gomoku_pkg::BOARD_N + c];
endfunction

function automatic gomoku_pkg::threat_level_t grade_cell(input gomoku_pkg::board_t b,
        input int r, input int c, input gomoku_pkg::cell_t col);
    int                        dr [4];
    int                        dc [4];
    int                        run;
    int                        open;
    int                        k;
    gomoku_pkg::threat_level_t lvl;
    gomoku_pkg::threat_level_t best;
    best = gomoku_pkg::NONE;
    if (cell_on_board(b, r, c) != gomoku_pkg::EMPTY)
        return best;
    dr = '{0, 1, 1, 1};
    dc = '{1, 0, 1, -1};
    for (int d = 0; d < 4; d++) begin
        run  = 1;
        open = 0;
        for (int s = -1; s <= 1; s += 2) begin
            k = 1;
            while (k <= 4 && cell_on_board(b, r + s * k * dr[d], c + s * k * dc[d]) == col)
                k++;
            run += k - 1;
            if (cell_on_board(b, r + s * k * dr[d], c + s * k * dc[d]) == gomoku_pkg::EMPTY)
                open++;
        end
        if (run >= gomoku_pkg::WIN_LEN)
            lvl = gomoku_pkg::FIVE;
        else if (run == 4 && open > 0)
            lvl = gomoku_pkg::FOUR;
        else if (run == 3 && open == 2)
            lvl = gomoku_pkg::OPEN_THREE;
        else
            lvl = gomoku_pkg::NONE;
        if (lvl > best)
            best = lvl;
    end
    return best;
endfunction

task automatic scan_pass_model(input gomoku_pkg::board_t b, input gomoku_pkg::cell_t col,
                               input int p);
    gomoku_pkg::threat_level_t lvl;
    pass_level[p] = gomoku_pkg::NONE;
    pass_cnt[p]   = 0;
    for (int i = 0; i < MAX_POS; i++) begin
        pass_x[p][i] = '0;
        pass_y[p][i] = '0;
    end
    for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
        for (int c = 0; c < gomoku_pkg::BOARD_N; c++) begin
            lvl = grade_cell(b, r, c, col);
            // a stronger level starts a fresh list
            if (lvl != gomoku_pkg::NONE && lvl > pass_level[p]) begin
                pass_level[p] = lvl;
                pass_cnt[p]   = 0;
                for (int i = 0; i < MAX_POS; i++) begin
                    pass_x[p][i] = '0;
                    pass_y[p][i] = '0;
                end
            end
            if (lvl != gomoku_pkg::NONE && lvl == pass_level[p]) begin
                if (pass_cnt[p] < MAX_POS) begin
                    pass_x[p][pass_cnt[p]] = gomoku_pkg::coord_t'(r);
                    pass_y[p][pass_cnt[p]] = gomoku_pkg::coord_t'(c);
                end
                if (pass_cnt[p] < 63)
                    pass_cnt[p]++;
            end
        end
    end
endtask

task automatic expect_result(input gomoku_pkg::board_t b, input logic turn);
    int win;
    scan_pass_model(b, turn ? gomoku_pkg::WHITE : gomoku_pkg::BLACK, 0);
    scan_pass_model(b, turn ? gomoku_pkg::BLACK : gomoku_pkg::WHITE, 1);
    // equal levels favour the side to move
    win        = (pass_level[0] >= pass_level[1]) ? 0 : 1;
    exp_level  = pass_level[win];
    exp_size   = 6'(pass_cnt[win]);
    exp_defend = (win == 1);
    for (int i = 0; i < MAX_POS; i++) begin
        exp_x[i] = pass_x[win][i];
        exp_y[i] = pass_y[win][i];
    end
endtask

task automatic clear_board();
    for (int i = 0; i < gomoku_pkg::NUM_CELLS; i++)
        stim_board[i] = gomoku_pkg::EMPTY;
endtask

task automatic put_stone(input int r, input int c, input gomoku_pkg::cell_t colour);
    stim_board[r * gomoku_pkg::BOARD_N + c] = colour;
endtask

task automatic random_board(input int pct_black, input int pct_white);
    int v;
    for (int i = 0; i < gomoku_pkg::NUM_CELLS; i++) begin
        v = {$random(seed)} % 100;
        if (v < pct_black)
            stim_board[i] = gomoku_pkg::BLACK;
        else if (v < pct_black + pct_white)
            stim_board[i] = gomoku_pkg::WHITE;
        else
            stim_board[i] = gomoku_pkg::EMPTY;
    end
endtask

// start_cyc ends up holding the count at the capture edge
task automatic start_scan(input logic turn);
    @(negedge i_clk);
    i_board = stim_board;
    i_turn  = turn;
    i_start = 1'b1;
    @(negedge i_clk);
    i_start   = 1'b0;
    start_cyc = cyc;
endtask

task automatic await_finish(input string tag);
    int elapsed;
    elapsed = 0;
    do begin
        @(negedge i_clk);
        elapsed = cyc - start_cyc;
        if (elapsed > gomoku_pkg::SCAN_LATENCY + 8)
            fail_run($sformatf("%s: no finish pulse within %0d cycles of start", tag, elapsed));
    end while (!o_finish);
    compare_cycles(elapsed, gomoku_pkg::SCAN_LATENCY, {tag, " latency"});
endtask

task automatic check_outputs(input string tag);
    compare_level(o_level, exp_level, {tag, " level"});
    compare_size(o_size, exp_size, {tag, " size"});
    compare_flag(o_defend, exp_defend, {tag, " defend"});
    for (int i = 0; i < MAX_POS; i++) begin
        compare_coord(o_pos_x[i*4 +: 4], exp_x[i], $sformatf("%s row slot %0d", tag, i));
        compare_coord(o_pos_y[i*4 +: 4], exp_y[i], $sformatf("%s col slot %0d", tag, i));
    end
endtask

task automatic run_case(input string tag, input logic turn);
    expect_result(stim_board, turn);
    start_scan(turn);
    await_finish(tag);
    check_outputs(tag);
endtask

task automatic test_reset_and_empty();
    compare_flag(o_finish, 1'b0, "finish after reset");
    compare_size(o_size, 6'd0, "size after reset");
    compare_level(o_level, gomoku_pkg::NONE, "level after reset");
    compare_flag(o_defend, 1'b0, "defend after reset");
    for (int i = 0; i < MAX_POS; i++) begin
        compare_coord(o_pos_x[i*4 +: 4], '0, $sformatf("reset row slot %0d", i));
        compare_coord(o_pos_y[i*4 +: 4], '0, $sformatf("reset col slot %0d", i));
    end
    clear_board();
    run_case("empty board", 1'b0);
    compare_level(o_level, gomoku_pkg::NONE, "empty board level");
    compare_size(o_size, 6'd0, "empty board size");
endtask

task automatic test_winning_point();
    clear_board();
    for (int c = 5; c <= 8; c++)
        put_stone(7, c, gomoku_pkg::BLACK);
    run_case("winning point", 1'b0);
    compare_level(o_level, gomoku_pkg::FIVE, "winning point level");
    compare_size(o_size, 6'd2, "winning point size");
    compare_coord(o_pos_x[3:0], 4'd7, "winning point first row");
    compare_coord(o_pos_y[3:0], 4'd4, "winning point first col");
    compare_coord(o_pos_x[7:4], 4'd7, "winning point second row");
    compare_coord(o_pos_y[7:4], 4'd9, "winning point second col");
endtask

task automatic test_forced_defence();
    clear_board();
    for (int c = 4; c <= 7; c++)
        put_stone(3, c, gomoku_pkg::WHITE);
    run_case("forced defence", 1'b0);
    compare_level(o_level, gomoku_pkg::FIVE, "forced defence level");
    compare_flag(o_defend, 1'b1, "forced defence flag");
    compare_coord(o_pos_y[3:0], 4'd3, "forced defence first col");
    compare_coord(o_pos_y[7:4], 4'd8, "forced defence second col");
endtask

// black open threes at row 1 come first in the scan and must be dropped
task automatic test_priority();
    clear_board();
    for (int c = 2; c <= 4; c++)
        put_stone(10, c, gomoku_pkg::BLACK);
    put_stone(1, 10, gomoku_pkg::BLACK);
    put_stone(1, 11, gomoku_pkg::BLACK);
    put_stone(2, 6, gomoku_pkg::WHITE);
    put_stone(2, 7, gomoku_pkg::WHITE);
    run_case("priority", 1'b0);
    compare_level(o_level, gomoku_pkg::FOUR, "priority level");
    compare_size(o_size, 6'd2, "priority size");
    compare_coord(o_pos_x[3:0], 4'd10, "priority first row");
    compare_coord(o_pos_y[3:0], 4'd1, "priority first col");
    compare_coord(o_pos_y[7:4], 4'd5, "priority second col");
    compare_coord(o_pos_x[11:8], 4'd0, "priority third row");
endtask

task automatic test_random_boards();
    logic turn;
    for (int n = 0; n < 10; n++) begin
        random_board(5 + 3 * n, 5 + 3 * n);
        turn = 1'($random(seed) & 1);
        run_case($sformatf("random board %0d", n), turn);
    end
endtask

// black pairs in columns 2-3, 7-8 and 12-13 leave five open threes per row
task automatic test_count_saturation();
    clear_board();
    for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
        for (int c = 2; c < gomoku_pkg::BOARD_N; c += 5) begin
            put_stone(r, c, gomoku_pkg::BLACK);
            put_stone(r, c + 1, gomoku_pkg::BLACK);
        end
    end
    run_case("count saturation", 1'b0);
    compare_level(o_level, gomoku_pkg::OPEN_THREE, "count saturation level");
    compare_size(o_size, 6'd63, "count saturation size");
endtask

task automatic test_start_while_busy();
    clear_board();
    for (int r = 3; r <= 6; r++)
        put_stone(r, 12, gomoku_pkg::WHITE);
    expect_result(stim_board, 1'b1);
    start_scan(1'b1);
    repeat (100) @(negedge i_clk);
    clear_board();
    i_board = stim_board;
    i_turn  = 1'b0;
    i_start = 1'b1;
    @(negedge i_clk);
    i_start = 1'b0;
    await_finish("start while busy");
    check_outputs("start while busy");
    compare_level(o_level, gomoku_pkg::FIVE, "start while busy level");
    repeat (gomoku_pkg::SCAN_LATENCY / 2) begin
        @(negedge i_clk);
        if (o_finish)
            fail_run("a second finish pulse followed the ignored start");
    end
endtask

`endif

//--- tests/tb_threats.sv
// testbench top with clock, reset, DUT instance, run limit and test sequence
`timescale 1ns/1ps

module tb_threats;

    localparam int MAX_POS     = 10;
    localparam int CLK_PERIOD  = 40;
    localparam int CYCLE_LIMIT = 20 * gomoku_pkg::SCAN_LATENCY;

    logic                      i_clk;
    logic                      i_rst_n;
    logic                      i_start;
    logic                      i_turn;
    gomoku_pkg::board_t        i_board;
    logic [MAX_POS*4-1:0]      o_pos_x;
    logic [MAX_POS*4-1:0]      o_pos_y;
    logic [5:0]                o_size;
    gomoku_pkg::threat_level_t o_level;
    logic                      o_defend;
    logic                      o_finish;

    gomoku_pkg::board_t        stim_board;
    integer                    seed;
    int                        cyc = 0;
    int                        start_cyc;

    `include "tb_threats_tasks.svh"

    threats #(
        .MAX_POS (MAX_POS)
    ) i_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_turn   (i_turn),
        .i_board  (i_board),
        .o_pos_x  (o_pos_x),
        .o_pos_y  (o_pos_y),
        .o_size   (o_size),
        .o_level  (o_level),
        .o_defend (o_defend),
        .o_finish (o_finish)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // posedge count that also enforces the run limit
    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT)
            fail_run("run limit reached before the tests finished");
    end

    initial begin
        seed      = 32'h7833;
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_turn    = 1'b0;
        start_cyc = 0;
        clear_board();
        i_board = stim_board;
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        test_reset_and_empty();
        test_winning_point();
        test_forced_defence();
        test_priority();
        test_random_boards();
        test_count_saturation();
        test_start_while_busy();
        $display("Result: PASSED");
        $finish;
    end

endmodule
